// File: verilog/video_pkg.sv
package video_pkg;

    ////////////////////
    // frame geometry
    localparam int line_width  = 16;
    localparam int frame_lines = 4;
    localparam int addr_bits   = 5;
    localparam int x_bits      = addr_bits - 1;
    localparam int line_bits   = $clog2(frame_lines);
    localparam int word_bits   = 12;
    localparam int pixel_bits  = 2 * word_bits;

    ////////////////////
    // timing in clocks
    localparam int in_h_start = 8;
    localparam int out_h_sync = 4;
    localparam int out_h_back = 6;

    // terminal counts for the sized counters
    localparam logic [x_bits-1:0]    x_last     = x_bits'(line_width - 1);
    localparam logic [x_bits-1:0]    porch_last = x_bits'(in_h_start - 2);
    localparam logic [x_bits-1:0]    sync_last  = x_bits'(out_h_sync - 1);
    localparam logic [x_bits-1:0]    back_last  = x_bits'(out_h_back - 1);
    localparam logic [line_bits-1:0] line_last  = line_bits'(frame_lines - 1);

    typedef enum logic [1:0] {
        c_idle,
        c_porch,
        c_active
    } capture_state_e;

    typedef enum logic [2:0] {
        o_wait,
        o_sync,
        o_back,
        o_active,
        o_repeat
    } output_state_e;

    // apb word addresses
    typedef enum logic [3:0] {
        reg_ctrl      = 4'h0,
        reg_highlight = 4'h4,
        reg_frames    = 4'h8
    } reg_addr_e;

endpackage

// File: verilog/line_buffer.sv
`timescale 1ns/1ps

module line_buffer (
    input  logic                              clock,
    input  logic                              wr_en,
    input  logic [video_pkg::addr_bits-1:0]   wr_addr,
    input  logic [video_pkg::pixel_bits-1:0]  wr_data,
    input  logic [video_pkg::addr_bits-1:0]   rd_addr,
    output logic [video_pkg::pixel_bits-1:0]  rd_data
);
    // two line halves, selected by the top address bit
    logic [video_pkg::pixel_bits-1:0] mem [0:(1 << video_pkg::addr_bits) - 1];

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, data one clock after address
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: verilog/video_capture.sv
`timescale 1ns/1ps

module video_capture (
    input  logic                               clock,
    input  logic                               rst,
    input  logic                               vin_hsync_n,
    input  logic                               vin_vsync_n,
    input  logic [video_pkg::word_bits-1:0]    vin_data,
    output logic                               wr_en,
    output logic [video_pkg::addr_bits-1:0]    wr_addr,
    output logic [video_pkg::pixel_bits-1:0]   wr_data,
    output logic                               line_ready,
    output logic                               line_half,
    output logic                               line_first,
    output logic                               frame_done
);
    video_pkg::capture_state_e state;
    logic hsync_q;
    logic vsync_q;
    logic hsync_fall;
    logic vsync_fall;
    logic [video_pkg::x_bits-1:0] cnt;
    logic phase;
    logic [video_pkg::word_bits-1:0] first_word;
    logic half;
    logic line_end;
    logic [video_pkg::line_bits-1:0] line_cnt;

    assign hsync_fall = hsync_q && !vin_hsync_n;
    assign vsync_fall = vsync_q && !vin_vsync_n;

    always_ff @(posedge clock) begin
        if (rst) begin
            hsync_q <= 1'b1;
            vsync_q <= 1'b1;
        end else begin
            hsync_q <= vin_hsync_n;
            vsync_q <= vin_vsync_n;
        end
    end

    ////////////////////
    // line sequencer
    always_ff @(posedge clock) begin
        if (rst) begin
            state    <= video_pkg::c_idle;
            cnt      <= '0;
            phase    <= 1'b0;
            wr_en    <= 1'b0;
            line_end <= 1'b0;
        end else begin
            wr_en    <= 1'b0;
            line_end <= 1'b0;
            if (hsync_fall) begin
                state <= video_pkg::c_porch;
                cnt   <= '0;
            end else begin
                case (state)
                    video_pkg::c_porch: begin
                        if (cnt == video_pkg::porch_last) begin
                            state <= video_pkg::c_active;
                            cnt   <= '0;
                            phase <= 1'b0;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    video_pkg::c_active: begin
                        phase <= !phase;
                        if (phase) begin
                            wr_en <= 1'b1;
                            cnt   <= cnt + 1'b1;
                            if (cnt == video_pkg::x_last) begin
                                state    <= video_pkg::c_idle;
                                line_end <= 1'b1;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // first word is red and upper green, second is lower green and blue
    always_ff @(posedge clock) begin
        if (state == video_pkg::c_active && !phase) begin
            first_word <= vin_data;
        end
        if (state == video_pkg::c_active && phase) begin
            wr_addr <= {half, cnt};
            wr_data <= {first_word, vin_data};
        end
    end

    ////////////////////
    // handoff to output
    always_ff @(posedge clock) begin
        if (rst) begin
            line_ready <= 1'b0;
            line_half  <= 1'b0;
            line_first <= 1'b0;
            frame_done <= 1'b0;
            half       <= 1'b0;
            line_cnt   <= '0;
        end else begin
            line_ready <= line_end;
            frame_done <= line_end && (line_cnt == video_pkg::line_last);
            if (line_end) begin
                line_half  <= half;
                line_first <= (line_cnt == '0);
                half       <= !half;
            end
            if (vsync_fall) begin
                line_cnt <= '0;
            end else if (line_end) begin
                line_cnt <= (line_cnt == video_pkg::line_last) ? '0 : line_cnt + 1'b1;
            end
        end
    end

endmodule

// File: verilog/video_output.sv
`timescale 1ns/1ps

module video_output (
    input  logic                              clock,
    input  logic                              rst,
    input  logic                              line_ready,
    input  logic                              line_half,
    input  logic                              line_first,
    input  logic [video_pkg::pixel_bits-1:0]  rd_data,
    input  logic                              line_doubler,
    input  logic                              osd_enable,
    input  logic [7:0]                        highlight_line,
    output logic [video_pkg::addr_bits-1:0]   rd_addr,
    output logic                              vout_hsync,
    output logic                              vout_vsync,
    output logic                              vout_de,
    output logic [video_pkg::pixel_bits-1:0]  vout_rgb
);
    video_pkg::output_state_e state;
    logic pend_valid;
    logic pend_half;
    logic pend_first;
    logic start;
    logic start_half;
    logic start_first;
    logic cur_half;
    logic cur_first;
    logic second;
    logic [video_pkg::x_bits-1:0] cnt;
    logic [video_pkg::x_bits-1:0] rd_x;
    logic [7:0] out_line;
    logic highlight;

    // pending entry wins over a pulse arriving in the same clock
    assign start       = (state == video_pkg::o_wait) && (pend_valid || line_ready);
    assign start_half  = pend_valid ? pend_half : line_half;
    assign start_first = pend_valid ? pend_first : line_first;

    ////////////////////
    // one-entry handoff
    always_ff @(posedge clock) begin
        if (rst) begin
            pend_valid <= 1'b0;
        end else if (line_ready && !(start && !pend_valid)) begin
            pend_valid <= 1'b1;
        end else if (start) begin
            pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (line_ready) begin
            pend_half  <= line_half;
            pend_first <= line_first;
        end
    end

    ////////////////////
    // line timing
    always_ff @(posedge clock) begin
        if (rst) begin
            state     <= video_pkg::o_wait;
            cnt       <= '0;
            second    <= 1'b0;
            cur_half  <= 1'b0;
            cur_first <= 1'b0;
            out_line  <= '0;
        end else begin
            case (state)
                video_pkg::o_wait: begin
                    if (start) begin
                        state     <= video_pkg::o_sync;
                        cnt       <= '0;
                        second    <= 1'b0;
                        cur_half  <= start_half;
                        cur_first <= start_first;
                        out_line  <= start_first ? '0 : out_line + 1'b1;
                    end
                end
                video_pkg::o_sync: begin
                    if (cnt == video_pkg::sync_last) begin
                        state <= video_pkg::o_back;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                video_pkg::o_back: begin
                    if (cnt == video_pkg::back_last) begin
                        state <= video_pkg::o_active;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                video_pkg::o_active: begin
                    if (cnt == video_pkg::x_last) begin
                        cnt   <= '0;
                        state <= (line_doubler && !second) ? video_pkg::o_repeat
                                                           : video_pkg::o_wait;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                video_pkg::o_repeat: begin
                    // same half again, next line number
                    state    <= video_pkg::o_sync;
                    second   <= 1'b1;
                    out_line <= out_line + 1'b1;
                end
                default: state <= video_pkg::o_wait;
            endcase
        end
    end

    // address runs one pixel ahead of de
    assign rd_x    = (state == video_pkg::o_active) ? cnt + 1'b1 : '0;
    assign rd_addr = {cur_half, rd_x};

    assign vout_hsync = (state == video_pkg::o_sync);
    assign vout_vsync = vout_hsync && cur_first && !second;
    assign vout_de    = (state == video_pkg::o_active);

    assign highlight = osd_enable && (out_line == highlight_line);
    assign vout_rgb  = !vout_de ? '0 : (highlight ? ~rd_data : rd_data);

endmodule

// File: verilog/video_config.sv
`timescale 1ns/1ps

module video_config (
    input  logic        clock,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    input  logic        frame_done,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        line_doubler,
    output logic        osd_enable,
    output logic [7:0]  highlight_line
);
    video_pkg::reg_addr_e addr;
    logic access;
    logic mapped;
    logic [15:0] frames;

    assign addr   = video_pkg::reg_addr_e'(paddr);
    assign access = psel && penable;

    // no wait states
    assign pready = 1'b1;

    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (addr)
            video_pkg::reg_ctrl:      prdata[1:0] = {osd_enable, line_doubler};
            video_pkg::reg_highlight: prdata[7:0] = highlight_line;
            video_pkg::reg_frames:    prdata[15:0] = frames;
            default:                  mapped = 1'b0;
        endcase
    end

    // frame counter is read only
    assign pslverr = access && (!mapped || (pwrite && addr == video_pkg::reg_frames));

    ////////////////////
    // register writes
    always_ff @(posedge clock) begin
        if (rst) begin
            line_doubler   <= 1'b0;
            osd_enable     <= 1'b0;
            highlight_line <= '0;
        end else if (access && pwrite) begin
            case (addr)
                video_pkg::reg_ctrl: begin
                    line_doubler <= pwdata[0];
                    osd_enable   <= pwdata[1];
                end
                video_pkg::reg_highlight: highlight_line <= pwdata[7:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            frames <= '0;
        end else if (frame_done) begin
            frames <= frames + 1'b1;
        end
    end

endmodule

// File: verilog/dcx_video.sv
`timescale 1ns/1ps

module dcx_video (
    input  logic                              clock,
    input  logic                              rst,
    input  logic                              vin_hsync_n,
    input  logic                              vin_vsync_n,
    input  logic [video_pkg::word_bits-1:0]   vin_data,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [3:0]                        paddr,
    input  logic [31:0]                       pwdata,
    output logic [31:0]                       prdata,
    output logic                              pready,
    output logic                              pslverr,
    output logic                              vout_hsync,
    output logic                              vout_vsync,
    output logic                              vout_de,
    output logic [video_pkg::pixel_bits-1:0]  vout_rgb
);
    logic wr_en;
    logic [video_pkg::addr_bits-1:0] wr_addr;
    logic [video_pkg::pixel_bits-1:0] wr_data;
    logic [video_pkg::addr_bits-1:0] rd_addr;
    logic [video_pkg::pixel_bits-1:0] rd_data;
    logic line_ready;
    logic line_half;
    logic line_first;
    logic frame_done;
    logic line_doubler;
    logic osd_enable;
    logic [7:0] highlight_line;

    ////////////////////
    // input side
    video_capture video_capture_i (
        .clock(clock), .rst(rst),
        .vin_hsync_n(vin_hsync_n), .vin_vsync_n(vin_vsync_n), .vin_data(vin_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .line_ready(line_ready), .line_half(line_half), .line_first(line_first),
        .frame_done(frame_done)
    );

    line_buffer line_buffer_i (
        .clock(clock),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    ////////////////////
    // output side
    video_output video_output_i (
        .clock(clock), .rst(rst),
        .line_ready(line_ready), .line_half(line_half), .line_first(line_first),
        .rd_addr(rd_addr), .rd_data(rd_data),
        .line_doubler(line_doubler), .osd_enable(osd_enable),
        .highlight_line(highlight_line),
        .vout_hsync(vout_hsync), .vout_vsync(vout_vsync), .vout_de(vout_de),
        .vout_rgb(vout_rgb)
    );

    video_config video_config_i (
        .clock(clock), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .frame_done(frame_done),
        .line_doubler(line_doubler), .osd_enable(osd_enable),
        .highlight_line(highlight_line)
    );

endmodule

// File: tests/dcx_video_tb.sv
`timescale 1ns/1ps

module dcx_video_tb;

    typedef struct packed {
        logic       doubler;
        logic       osd;
        logic [7:0] highlight;
        logic [3:0] frames;
    } scenario_t;

    localparam int pix = video_pkg::pixel_bits;
    localparam int line_width = video_pkg::line_width;
    localparam int line_clocks = 80;
    localparam int apb_limit = 20;
    localparam int run_limit = 500;
    localparam int scenario_count = 5;

    logic clock;
    logic rst;
    logic vin_hsync_n;
    logic vin_vsync_n;
    logic [video_pkg::word_bits-1:0] vin_data;
    logic psel;
    logic penable;
    logic pwrite;
    logic [3:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic vout_hsync;
    logic vout_vsync;
    logic vout_de;
    logic [pix-1:0] vout_rgb;

    int pixel_errors;
    int timing_errors;
    int reg_errors;
    logic [15:0] lfsr;
    scenario_t scenarios [scenario_count];

    // expected pixels in input order, and the de runs seen at the output
    logic [pix-1:0] exp_q [$];
    logic [line_width*pix-1:0] run_q [$];
    logic vs_q [$];

    int hs_cnt;
    int gap_cnt;
    int de_cnt;
    logic run_vs;
    logic [line_width*pix-1:0] run_pix;

    dcx_video dcx_video_i (.*);

    always #10 clock = !clock;

    ////////////////////
    // helpers
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [video_pkg::word_bits-1:0] random_word();
        logic [video_pkg::word_bits-1:0] w;
        w = '0;
        for (int i = 0; i < video_pkg::word_bits; i++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[video_pkg::word_bits-2:0], lfsr[0]};
        end
        return w;
    endfunction

    // red and upper green in the first word, lower green and blue in the second
    function automatic logic [pix-1:0] rebuild_pixel(input logic [11:0] w0, input logic [11:0] w1);
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
        red = w0[11:4];
        green = {w0[3:0], w1[11:8]};
        blue = w1[7:0];
        return {red, green, blue};
    endfunction

    task automatic report_and_finish();
        $display("pixel errors: %0d, timing errors: %0d, register errors: %0d",
                 pixel_errors, timing_errors, reg_errors);
        if (pixel_errors + timing_errors + reg_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    task automatic apb_access(input logic write, input logic [3:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int n;
        @(posedge clock);
        #2;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(posedge clock);
        #2;
        penable = 1'b1;
        n = 0;
        @(negedge clock);
        while (!pready) begin
            if (n == apb_limit) begin
                timing_errors++;
                $display("APB access to address %0d never completed", addr);
                report_and_finish();
            end
            n++;
            @(negedge clock);
        end
        rdata = prdata;
        err = pslverr;
        @(posedge clock);
        #2;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] rdata;
        logic err;
        apb_access(1'b1, addr, data, rdata, err);
        assert (err == exp_err) else begin
            reg_errors++;
            $display("** Error at %0t: write to address %0d gave pslverr %0b", $time, addr, err);
        end
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        assert (!err) else begin
            reg_errors++;
            $display("** Error at %0t: read of address %0d gave pslverr", $time, addr);
        end
    endtask

    task automatic check_reg(input logic [3:0] addr, input logic [31:0] expected,
                             input logic exp_err);
        logic [31:0] rdata;
        logic err;
        apb_access(1'b0, addr, '0, rdata, err);
        assert (err == exp_err && (exp_err || rdata == expected)) else begin
            reg_errors++;
            $display("** Error at %0t: address %0d read %h pslverr %0b, expected %h",
                     $time, addr, rdata, err, expected);
        end
    endtask

    ////////////////////
    // video source
    task automatic send_line(input logic first);
        logic [video_pkg::word_bits-1:0] words [2*line_width];
        int n;
        for (int k = 0; k < line_width; k++) begin
            words[2*k] = random_word();
            words[2*k+1] = random_word();
            exp_q.push_back(rebuild_pixel(words[2*k], words[2*k+1]));
        end
        // syncs low for 4 clocks, first word in_h_start clocks after the fall
        for (int c = 0; c < line_clocks; c++) begin
            @(posedge clock);
            #2;
            vin_hsync_n = (c >= 4);
            vin_vsync_n = !(first && c < 4);
            n = c - video_pkg::in_h_start;
            vin_data = (n >= 0 && n < 2 * line_width) ? words[n] : '0;
        end
    endtask

    task automatic wait_runs(input int count);
        int n;
        n = 0;
        while (run_q.size() < count) begin
            if (n == run_limit) begin
                timing_errors++;
                $display("timed out with %0d of %0d output lines", run_q.size(), count);
                report_and_finish();
            end
            n++;
            @(posedge clock);
        end
        // no extra lines may follow
        repeat (60) @(posedge clock);
        assert (run_q.size() == count) else begin
            timing_errors++;
            $display("** Error at %0t: %0d output lines, expected %0d",
                     $time, run_q.size(), count);
        end
    endtask

    task automatic check_runs(input scenario_t sc);
        int mult;
        int line;
        int copy;
        int num;
        logic [pix-1:0] expv;
        logic [pix-1:0] got;
        logic exp_vs;
        mult = sc.doubler ? 2 : 1;
        for (int r = 0; r < run_q.size(); r++) begin
            line = r / mult;
            copy = r % mult;
            num = (line % video_pkg::frame_lines) * mult + copy;
            exp_vs = (line % video_pkg::frame_lines == 0) && (copy == 0);
            assert (vs_q[r] == exp_vs) else begin
                timing_errors++;
                $display("** Error at %0t: output line %0d vsync %0b, expected %0b",
                         $time, r, vs_q[r], exp_vs);
            end
            for (int k = 0; k < line_width; k++) begin
                expv = exp_q[line*line_width+k];
                if (sc.osd && num == int'(sc.highlight)) begin
                    expv = ~expv;
                end
                got = run_q[r][k*pix +: pix];
                assert (got == expv) else begin
                    pixel_errors++;
                    $display("** Error at %0t: output line %0d pixel %0d is %h, expected %h",
                             $time, r, k, got, expv);
                end
            end
        end
    endtask

    ////////////////////
    // output collector
    always @(negedge clock) begin
        if (rst) begin
            hs_cnt = 0;
            gap_cnt = 0;
            de_cnt = 0;
            run_vs = 1'b0;
        end else begin
            assert (!vout_vsync || vout_hsync) else begin
                timing_errors++;
                $display("** Error at %0t: vsync high outside hsync", $time);
            end
            if (!vout_de && de_cnt != 0) begin
                assert (de_cnt == line_width) else begin
                    timing_errors++;
                    $display("** Error at %0t: de run of %0d clocks", $time, de_cnt);
                end
                run_q.push_back(run_pix);
                vs_q.push_back(run_vs);
                de_cnt = 0;
                hs_cnt = 0;
                gap_cnt = 0;
                run_vs = 1'b0;
            end
            if (vout_hsync) begin
                hs_cnt++;
                run_vs = run_vs | vout_vsync;
            end else if (vout_de) begin
                if (de_cnt == 0) begin
                    assert (hs_cnt == video_pkg::out_h_sync && gap_cnt == video_pkg::out_h_back)
                    else begin
                        timing_errors++;
                        $display("** Error at %0t: hsync %0d and back porch %0d clocks",
                                 $time, hs_cnt, gap_cnt);
                    end
                end
                if (de_cnt < line_width) begin
                    run_pix[de_cnt*pix +: pix] = vout_rgb;
                end
                de_cnt++;
            end else if (hs_cnt != 0) begin
                gap_cnt++;
            end
        end
    end

    ////////////////////
    // main sequence
    initial begin
        logic [31:0] frames_before;
        int mult;
        clock = 1'b0;
        rst = 1'b1;
        vin_hsync_n = 1'b1;
        vin_vsync_n = 1'b1;
        vin_data = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        pixel_errors = 0;
        timing_errors = 0;
        reg_errors = 0;
        lfsr = 16'd40600;

        // doubler, osd, highlight line, frames
        scenarios[0] = '{1'b0, 1'b0, 8'd0, 4'd2};
        scenarios[1] = '{1'b1, 1'b0, 8'd0, 4'd1};
        scenarios[2] = '{1'b0, 1'b1, 8'd2, 4'd1};
        scenarios[3] = '{1'b1, 1'b1, 8'd3, 4'd2};
        scenarios[4] = '{1'b0, 1'b1, 8'd9, 4'd1};

        repeat (10) @(posedge clock);
        #2;
        rst = 1'b0;

        check_reg(video_pkg::reg_ctrl, 32'd0, 1'b0);
        check_reg(video_pkg::reg_highlight, 32'd0, 1'b0);
        check_reg(video_pkg::reg_frames, 32'd0, 1'b0);

        for (int s = 0; s < scenario_count; s++) begin
            write_reg(video_pkg::reg_ctrl, {30'd0, scenarios[s].osd, scenarios[s].doubler}, 1'b0);
            write_reg(video_pkg::reg_highlight, {24'd0, scenarios[s].highlight}, 1'b0);
            check_reg(video_pkg::reg_ctrl, {30'd0, scenarios[s].osd, scenarios[s].doubler}, 1'b0);
            check_reg(video_pkg::reg_highlight, {24'd0, scenarios[s].highlight}, 1'b0);
            read_reg(video_pkg::reg_frames, frames_before);
            exp_q.delete();
            run_q.delete();
            vs_q.delete();
            for (int f = 0; f < int'(scenarios[s].frames); f++) begin
                for (int l = 0; l < video_pkg::frame_lines; l++) begin
                    send_line(l == 0);
                end
            end
            mult = scenarios[s].doubler ? 2 : 1;
            wait_runs(int'(scenarios[s].frames) * video_pkg::frame_lines * mult);
            check_runs(scenarios[s]);
            check_reg(video_pkg::reg_frames, frames_before + 32'(scenarios[s].frames), 1'b0);
        end

        // error responses leave the registers alone
        read_reg(video_pkg::reg_frames, frames_before);
        write_reg(video_pkg::reg_frames, 32'h1234, 1'b1);
        check_reg(video_pkg::reg_frames, frames_before, 1'b0);
        write_reg(4'd12, 32'h3, 1'b1);
        check_reg(4'd12, 32'd0, 1'b1);
        check_reg(video_pkg::reg_ctrl, 32'd2, 1'b0);
        check_reg(video_pkg::reg_highlight, 32'd9, 1'b0);

        report_and_finish();
    end

endmodule

// File: project.f
verilog/video_pkg.sv
verilog/line_buffer.sv
verilog/video_capture.sv
verilog/video_output.sv
verilog/video_config.sv
verilog/dcx_video.sv
tests/dcx_video_tb.sv

// File: Makefile
SOURCES := $(shell cat project.f)

build/Vdcx_video_tb: project.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module dcx_video_tb \
		--Mdir build -f project.f

.PHONY: run clean

run: build/Vdcx_video_tb
	@out="$$(./build/Vdcx_video_tb)"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf build
